//--- Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_mem_subsys \
		-f flist.f --Mdir obj_dir -o sim_mem_subsys

run: compile
	./obj_dir/sim_mem_subsys | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bus_port.sv
`timescale 1ns/1ps
`default_nettype none

// Request queue for one master. The master owns FIFO_DEPTH credits,
// so a push never lands on a full queue.
module bus_port
    import mem_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           req_valid,
    input  wire bus_req_t req,
    input  wire           pop,
    output bus_req_t      head,
    output logic          head_valid,
    output logic          credit_return
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);

    bus_req_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wraps at any depth, not only powers of two.
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage and pointers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or push and pop together.
            endcase
        end
    end

    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    // One credit back for every entry that leaves.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
mem_pkg.sv
bus_port.sv
port_arbiter.sv
sram_ctrl.sv
mem_subsys_top.sv
sram_model.sv
tb_mem_subsys.sv

//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus request and response.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_W = 30;  // Word address, byte lanes picked by be.

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef struct packed {
        mem_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
        logic [3:0]        be;     // Active high.
    } bus_req_t;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] rdata;        // Zero on writes.
    } bus_rsp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SRAM controller FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_SETUP  = 2'd1,
        S_STROBE = 2'd2,
        S_DONE   = 2'd3
    } sram_state_e;

endpackage

`default_nettype wire

//--- mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top
    import mem_pkg::*;
#(
    parameter int NUM_PORTS  = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire [NUM_PORTS-1:0]           req_valid,
    input  wire bus_req_t [NUM_PORTS-1:0] req,
    output wire [NUM_PORTS-1:0]           credit_return,
    output wire [NUM_PORTS-1:0]           rsp_valid,
    output wire bus_rsp_t [NUM_PORTS-1:0] rsp,
    output wire [ADDR_W-1:0]              ram_address,
    output wire                           ram_wr_n,
    output wire                           ram_rd_n,
    output wire [3:0]                     ram_dataenable,
    inout  wire [31:0]                    ram_data
);

    wire bus_req_t [NUM_PORTS-1:0] head;
    wire [NUM_PORTS-1:0]           head_valid;
    wire [NUM_PORTS-1:0]           pop;

    wire           acc_valid;
    wire bus_req_t acc;
    wire           acc_ready;
    wire           done;
    wire bus_rsp_t done_rsp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per-master request queues.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
        bus_port #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_port (
            .clk           (clk),
            .rst_n         (rst_n),
            .req_valid     (req_valid[g]),
            .req           (req[g]),
            .pop           (pop[g]),
            .head          (head[g]),
            .head_valid    (head_valid[g]),
            .credit_return (credit_return[g])
        );
    end

    port_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .head       (head),
        .head_valid (head_valid),
        .acc_ready  (acc_ready),
        .done       (done),
        .done_rsp   (done_rsp),
        .pop        (pop),
        .acc_valid  (acc_valid),
        .acc        (acc),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    sram_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .acc_valid      (acc_valid),
        .acc            (acc),
        .acc_ready      (acc_ready),
        .done           (done),
        .done_rsp       (done_rsp),
        .ram_address    (ram_address),
        .ram_wr_n       (ram_wr_n),
        .ram_rd_n       (ram_rd_n),
        .ram_dataenable (ram_dataenable),
        .ram_data       (ram_data)
    );

endmodule

`default_nettype wire

//--- port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module port_arbiter
    import mem_pkg::*;
#(
    parameter int NUM_PORTS = 2
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire bus_req_t [NUM_PORTS-1:0] head,
    input  wire [NUM_PORTS-1:0]           head_valid,
    input  wire                           acc_ready,
    input  wire                           done,
    input  wire bus_rsp_t                 done_rsp,
    output logic [NUM_PORTS-1:0]          pop,
    output logic                          acc_valid,
    output bus_req_t                      acc,
    output logic [NUM_PORTS-1:0]          rsp_valid,
    output bus_rsp_t [NUM_PORTS-1:0]      rsp
);

    localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [IDX_W-1:0] last_grant;  // Also the owner of the access in flight.
    logic [IDX_W-1:0] grant_idx;
    logic             grant_found;
    int               cand;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin pick.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Search starts one past the last grant and ends on the last grant itself.
    always_comb begin
        grant_found = 1'b0;
        grant_idx   = last_grant;
        cand        = 0;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = (int'(last_grant) + i) % NUM_PORTS;
            if (!grant_found && head_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx   = IDX_W'(cand);
            end
        end
    end

    assign acc_valid = acc_ready && grant_found;
    assign acc       = head[grant_idx];
    assign pop       = acc_valid ? (NUM_PORTS'(1) << grant_idx) : '0;

    // Only one access is in flight, so the next grant cannot land before done.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_grant <= IDX_W'(NUM_PORTS - 1);  // Port 0 first after reset.
        end else if (acc_valid) begin
            last_grant <= grant_idx;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response steering.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= '0;
        end else begin
            rsp_valid <= done ? (NUM_PORTS'(1) << last_grant) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            rsp[last_grant] <= done_rsp;
        end
    end

endmodule

`default_nettype wire

//--- sram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// Two-phase access on an asynchronous SRAM.
// SETUP puts out address, lanes and write data; STROBE pulses rd_n or wr_n.
module sram_ctrl
    import mem_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire                acc_valid,
    input  wire bus_req_t      acc,
    output logic               acc_ready,
    output logic               done,
    output bus_rsp_t           done_rsp,
    output logic [ADDR_W-1:0]  ram_address,
    output logic               ram_wr_n,
    output logic               ram_rd_n,
    output logic [3:0]         ram_dataenable,
    inout  wire  [31:0]        ram_data
);

    sram_state_e state;
    sram_state_e state_nxt;
    bus_req_t    req_q;
    logic        accept;
    logic        data_oe;
    logic        active_nxt;
    mem_op_e     cur_op;
    logic [3:0]  cur_be;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State machine.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign acc_ready = (state == S_IDLE);
    assign accept    = acc_valid && acc_ready;
    assign done      = (state == S_DONE);

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:   if (accept) state_nxt = S_SETUP;
            S_SETUP:  state_nxt = S_STROBE;
            S_STROBE: state_nxt = S_DONE;
            S_DONE:   state_nxt = S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= acc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pin drivers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Strobes come straight from flops, decoded one cycle ahead.
    assign cur_op     = accept ? acc.op : req_q.op;  // req_q is not loaded yet.
    assign cur_be     = accept ? acc.be : req_q.be;
    assign active_nxt = (state_nxt == S_SETUP) || (state_nxt == S_STROBE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_rd_n       <= 1'b1;
            ram_wr_n       <= 1'b1;
            ram_dataenable <= 4'hf;
            data_oe        <= 1'b0;
        end else begin
            ram_rd_n       <= !((state_nxt == S_STROBE) && (cur_op == MEM_READ));
            ram_wr_n       <= !((state_nxt == S_STROBE) && (cur_op == MEM_WRITE));
            ram_dataenable <= active_nxt ? ~cur_be : 4'hf;
            data_oe        <= active_nxt && (cur_op == MEM_WRITE);
        end
    end

    assign ram_address = req_q.addr;
    assign ram_data    = data_oe ? req_q.wdata : 32'bz;

    // Read data is taken on the edge that ends STROBE.
    always_ff @(posedge clk) begin
        if (state == S_STROBE) begin
            done_rsp.op    <= req_q.op;
            done_rsp.rdata <= (req_q.op == MEM_READ) ? ram_data : '0;
        end
    end

endmodule

`default_nettype wire

//--- sram_model.sv
`timescale 1ns/1ps
`default_nettype none

// Asynchronous SRAM for simulation. Only the low address bits decode.
module sram_model
    import mem_pkg::*;
#(
    parameter int DEPTH = 1024
) (
    input  wire [ADDR_W-1:0] ram_address,
    inout  wire [31:0]       ram_data,
    input  wire              ram_wr_n,
    input  wire              ram_rd_n,
    input  wire [3:0]        ram_dataenable
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [31:0]      mem [DEPTH];
    logic [IDX_W-1:0] idx;

    assign idx = ram_address[IDX_W-1:0];

    // Address, lanes and data have been stable since SETUP when wr_n falls.
    always @(negedge ram_wr_n) begin
        for (int b = 0; b < 4; b++) begin
            if (!ram_dataenable[b]) begin
                mem[idx][8*b +: 8] = ram_data[8*b +: 8];
            end
        end
    end

    // Full word out while rd_n is low.
    assign ram_data = !ram_rd_n ? mem[idx] : 32'bz;

endmodule

`default_nettype wire

//--- tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys
    import mem_pkg::*;
();

    localparam int NUM_PORTS  = 2;
    localparam int FIFO_DEPTH = 4;
    localparam int MEM_WORDS  = 1024;
    localparam int RING       = 1024;
    localparam int TIMEOUT_CYCLES = 2000;  // About 260 accesses of 4 cycles, twice over.

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic [NUM_PORTS-1:0]           req_valid;
    bus_req_t [NUM_PORTS-1:0]       req;
    wire  [NUM_PORTS-1:0]           credit_return;
    wire  [NUM_PORTS-1:0]           rsp_valid;
    wire  bus_rsp_t [NUM_PORTS-1:0] rsp;
    wire  [ADDR_W-1:0]              ram_address;
    wire                            ram_wr_n;
    wire                            ram_rd_n;
    wire  [3:0]                     ram_dataenable;
    wire  [31:0]                    ram_data;

    logic [31:0] ref_mem  [MEM_WORDS];
    bus_rsp_t    exp_rsp  [NUM_PORTS][RING];
    bus_rsp_t    got_rsp  [NUM_PORTS][RING];
    int          exp_cnt  [NUM_PORTS] = '{default: 0};
    int          got_cnt  [NUM_PORTS] = '{default: 0};
    int          chk_idx  [NUM_PORTS] = '{default: 0};
    int          sent     [NUM_PORTS] = '{default: 0};
    int          returned [NUM_PORTS] = '{default: 0};
    int          stalls   [NUM_PORTS] = '{default: 0};
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          seed   = 32'h427715e1;

    mem_subsys_top #(
        .NUM_PORTS  (NUM_PORTS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (.*);

    sram_model #(.DEPTH(MEM_WORDS)) u_sram (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Pulses are a full cycle wide, so the falling edge sees each once.
    always @(negedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (credit_return[p]) returned[p] = returned[p] + 1;
            if (rsp_valid[p]) begin
                got_rsp[p][got_cnt[p] % RING] = rsp[p];
                got_cnt[p] = got_cnt[p] + 1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int credits(input int p);
        return FIFO_DEPTH - (sent[p] - returned[p]);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) w[8*b +: 8] = new_word[8*b +: 8];
        end
        return w;
    endfunction

    function automatic bus_req_t mk_req(input mem_op_e op, input int addr,
                                        input logic [31:0] wdata, input logic [3:0] be);
        bus_req_t r;
        r.op    = op;
        r.addr  = ADDR_W'(addr);
        r.wdata = wdata;
        r.be    = be;
        return r;
    endfunction

    function automatic bus_req_t rand_req(input int base);
        bus_req_t r;
        r.op    = ($random(seed) & 1) ? MEM_WRITE : MEM_READ;
        r.addr  = ADDR_W'(base + ($random(seed) & 7));
        r.wdata = $random(seed);
        r.be    = 4'($random(seed));
        if (r.op == MEM_READ) begin
            r.wdata = '0;
            r.be    = 4'hf;
        end
        return r;
    endfunction

    function automatic bit all_done();
        bit d;
        d = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (got_cnt[p] < exp_cnt[p] || returned[p] < sent[p]) d = 1'b0;
        end
        return d;
    endfunction

    task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input int port);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("MISMATCH at %0t: rsp[%0d] got %s %h, expected %s %h", $time, port,
                     got.op.name(), got.rdata, exp.op.name(), exp.rdata);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string name);
        checks = checks + 1;
        if (got != exp) begin
            errors = errors + 1;
            $display("MISMATCH at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic expect_req(input int p, input bus_req_t r);
        bus_rsp_t e;
        int       a;
        a       = int'(r.addr) % MEM_WORDS;
        e.op    = r.op;
        e.rdata = '0;
        if (r.op == MEM_WRITE) ref_mem[a] = merge_bytes(ref_mem[a], r.wdata, r.be);
        else e.rdata = ref_mem[a];
        exp_rsp[p][exp_cnt[p] % RING] = e;
        exp_cnt[p] = exp_cnt[p] + 1;
    endtask

    task automatic drain_checks();
        for (int p = 0; p < NUM_PORTS; p++) begin
            while (chk_idx[p] < got_cnt[p]) begin
                if (chk_idx[p] >= exp_cnt[p]) begin
                    errors = errors + 1;
                    $display("[%0t] Port %0d returned a response with no request outstanding",
                             $time, p);
                end else begin
                    check_rsp(got_rsp[p][chk_idx[p] % RING], exp_rsp[p][chk_idx[p] % RING], p);
                end
                chk_idx[p] = chk_idx[p] + 1;
            end
            if (credits(p) > FIFO_DEPTH) begin
                errors = errors + 1;
                $display("[%0t] Port %0d returned more credits than it took requests", $time, p);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drivers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Entered and left 2 ns after a rising edge.
    task automatic issue(input logic [1:0] sel, input bus_req_t r0, input bus_req_t r1);
        bus_req_t r [NUM_PORTS];
        r[0] = r0;
        r[1] = r1;
        while ((sel[0] && credits(0) == 0) || (sel[1] && credits(1) == 0)) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (sel[p] && credits(p) == 0) stalls[p] = stalls[p] + 1;
            end
            @(posedge clk);
            #2;
            drain_checks();
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (sel[p]) begin
                req[p]  = r[p];
                sent[p] = sent[p] + 1;
                expect_req(p, r[p]);
            end
        end
        req_valid = sel;
        @(posedge clk);
        #2;
        req_valid = '0;
        drain_checks();
    endtask

    task automatic wait_idle();
        while (!all_done()) begin
            @(posedge clk);
            #2;
            drain_checks();
        end
    endtask

    task automatic apply_reset();
        rst_n     = 1'b0;
        req_valid = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic report_test(input string name, input int e0, input int c0);
        $display("[%0t] %s: %0d checks, %0d errors", $time, name, checks - c0, errors - e0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_write_read();
        int e0 = errors;
        int c0 = checks;
        issue(2'b01, mk_req(MEM_WRITE, 'h010, 32'hdeadbeef, 4'hf), '0);
        while (ram_wr_n) begin
            @(negedge clk);  // Wait for the write strobe.
        end
        check_count(ram_address, 'h010, "ram_address");
        @(posedge clk);
        #2;
        drain_checks();
        issue(2'b01, mk_req(MEM_READ, 'h010, '0, 4'hf), '0);
        wait_idle();
        report_test("write_read", e0, c0);
    endtask

    task automatic test_byte_merge();
        int e0 = errors;
        int c0 = checks;
        issue(2'b01, mk_req(MEM_WRITE, 'h020, 32'h11223344, 4'hf), '0);
        issue(2'b01, mk_req(MEM_WRITE, 'h020, 32'haaaaaaaa, 4'b0001), '0);
        issue(2'b01, mk_req(MEM_WRITE, 'h020, 32'h55667788, 4'b1100), '0);
        issue(2'b01, mk_req(MEM_WRITE, 'h020, 32'hcc00cc00, 4'b0100), '0);
        issue(2'b01, mk_req(MEM_READ, 'h020, '0, 4'hf), '0);
        wait_idle();
        report_test("byte_merge", e0, c0);
    endtask

    task automatic test_credits();
        int e0 = errors;
        int c0 = checks;
        int r0 = returned[1];
        stalls[1] = 0;
        for (int i = 0; i < 2 * FIFO_DEPTH; i++) begin
            issue(2'b10, '0, mk_req((i < FIFO_DEPTH + 2) ? MEM_WRITE : MEM_READ,
                                    'h040 + (i % 4), 32'h0c000000 + i, 4'hf));
        end
        wait_idle();
        check_count(returned[1] - r0, 2 * FIFO_DEPTH, "credit_return[1] pulses");
        check_count(int'(stalls[1] > 0), 1, "port 1 held back by credits");
        report_test("credits", e0, c0);
    endtask

    task automatic test_two_port_reads();
        int e0 = errors;
        int c0 = checks;
        int g0;
        int g1;
        for (int i = 0; i < 4; i++) begin
            issue(2'b11, mk_req(MEM_WRITE, 'h060 + i, 32'ha0a00000 + i, 4'hf),
                         mk_req(MEM_WRITE, 'h070 + i, 32'hb0b00000 + i, 4'hf));
        end
        wait_idle();
        g0 = got_cnt[0];
        g1 = got_cnt[1];
        for (int i = 0; i < 4; i++) begin
            issue(2'b11, mk_req(MEM_READ, 'h060 + i, '0, 4'hf),
                         mk_req(MEM_READ, 'h070 + i, '0, 4'hf));
        end
        wait_idle();
        check_count(got_cnt[0] - g0, 4, "rsp_valid[0] pulses");
        check_count(got_cnt[1] - g1, 4, "rsp_valid[1] pulses");
        report_test("two_port_reads", e0, c0);
    endtask

    task automatic test_random();
        int         e0 = errors;
        int         c0 = checks;
        int         n = 0;
        logic [1:0] sel;
        // Defined contents first, so every read has a known value.
        for (int i = 0; i < 8; i++) begin
            issue(2'b11, mk_req(MEM_WRITE, 'h100 + i, $random(seed), 4'hf),
                         mk_req(MEM_WRITE, 'h110 + i, $random(seed), 4'hf));
        end
        while (n < 200) begin
            sel = 2'($random(seed));
            if (n == 199) sel[1] = 1'b0;
            if (sel != 2'b00) begin
                n = n + int'(sel[0]) + int'(sel[1]);
                issue(sel, rand_req('h100), rand_req('h110));
            end
        end
        wait_idle();
        report_test("random", e0, c0);
    endtask

    task automatic test_idle_after_reset();
        int e0 = errors;
        int c0 = checks;
        int g;
        int r;
        apply_reset();
        g = got_cnt[0] + got_cnt[1];
        r = returned[0] + returned[1];
        repeat (20) begin
            @(negedge clk);
            check_count(ram_wr_n, 1, "ram_wr_n");
            check_count(ram_rd_n, 1, "ram_rd_n");
            check_count(ram_dataenable, 4'hf, "ram_dataenable");
        end
        @(posedge clk);
        #2;
        check_count(got_cnt[0] + got_cnt[1] - g, 0, "rsp_valid pulses");
        check_count(returned[0] + returned[1] - r, 0, "credit_return pulses");
        report_test("idle_after_reset", e0, c0);
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = '0;
        req       = '0;
        apply_reset();
        test_write_read();
        test_byte_merge();
        test_credits();
        test_two_port_reads();
        test_random();
        test_idle_after_reset();
        $display("Summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
